// ==== bench/ex_subsys_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_subsys_tb import ex_pkg::*; ();

    typedef struct {
        string               name;
        id_ex_t              op;
        logic [WORD_SIZE-1:0] mem_res;
        logic [WORD_SIZE-1:0] wb_res;
        logic [REG_SIZE-1:0]  rs1;
        logic [REG_SIZE-1:0]  rs2;
        int                   stall_cycles;
        ex_mem_t              exp_mem;
        redirect_t            exp_redirect;
    } vector_t;

    logic                 clk;
    logic                 rst_n;
    id_ex_t               id_ex;
    logic [REG_SIZE-1:0]  id_rs1;
    logic [REG_SIZE-1:0]  id_rs2;
    logic [WORD_SIZE-1:0] mem_res;
    logic [WORD_SIZE-1:0] wb_res;
    ex_mem_t              ex_mem;
    redirect_t            redirect;
    logic                 stall;

    vector_t     vectors_q[$];
    logic        vectors_ready = 1'b0;
    logic [31:0] lfsr_state = 32'haefc;

    ex_subsys #(
        .WORD_SIZE (WORD_SIZE)
    ) DUT (
        .clk_i      (clk),
        .rst_n_i    (rst_n),
        .id_ex_i    (id_ex),
        .id_rs1_i   (id_rs1),
        .id_rs2_i   (id_rs2),
        .mem_res_i  (mem_res),
        .wb_res_i   (wb_res),
        .ex_mem_o   (ex_mem),
        .redirect_o (redirect),
        .stall_o    (stall)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Galois form with taps x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic out;
        out = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        return out;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic [WORD_SIZE-1:0] pick_source(input bypass_sel_e sel,
            input logic [WORD_SIZE-1:0] reg_val, input logic [WORD_SIZE-1:0] mem_val,
            input logic [WORD_SIZE-1:0] wb_val);
        if (sel == MEM_BYPASS) return mem_val;
        if (sel == WB_BYPASS) return wb_val;
        return reg_val;
    endfunction

    // Reference model of the execute result
    function automatic logic [WORD_SIZE-1:0] ref_result(input alu_opcode_e opc,
            input logic [WORD_SIZE-1:0] a, input logic [WORD_SIZE-1:0] b,
            input logic [WORD_SIZE-1:0] ret_addr);
        case (opc)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return $signed(a) >>> b[4:0];
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_JAL:  return ret_addr;
            ALU_MUL:  return a * b;
            default:  return a + b;
        endcase
    endfunction

    function automatic logic ref_taken(input alu_opcode_e opc,
            input logic [WORD_SIZE-1:0] x, input logic [WORD_SIZE-1:0] y);
        case (opc)
            ALU_BEQ: return x == y;
            ALU_BNE: return x != y;
            ALU_BLT: return $signed(x) < $signed(y);
            ALU_BGE: return $signed(x) >= $signed(y);
            ALU_JAL: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic id_ex_t make_op(input alu_opcode_e opc);
        id_ex_t op;
        op = '0;
        op.valid      = 1'b1;
        op.opcode     = opc;
        op.alu_src_a  = rand_bits(32);
        op.alu_src_b  = rand_bits(32);
        op.br_src_a   = rand_bits(32);
        op.br_src_b   = rand_bits(32);
        op.pc         = rand_bits(30) << 2;
        op.rf_we      = 1'b1;
        op.rf_waddr   = 5'(rand_bits(5));
        op.st_data    = rand_bits(32);
        op.memop_type = WORD;
        op.is_jal     = (opc == ALU_JAL);
        return op;
    endfunction

    task automatic add_entry(input string name, input id_ex_t op,
            input logic [WORD_SIZE-1:0] mem_v, input logic [WORD_SIZE-1:0] wb_v,
            input logic [REG_SIZE-1:0] rs1, input logic [REG_SIZE-1:0] rs2, input int cycles);
        vector_t              e;
        logic [WORD_SIZE-1:0] a;
        logic [WORD_SIZE-1:0] b;
        logic [WORD_SIZE-1:0] bra;
        logic [WORD_SIZE-1:0] brb;
        a   = pick_source(op.sel_a, op.alu_src_a, mem_v, wb_v);
        b   = pick_source(op.sel_b, op.alu_src_b, mem_v, wb_v);
        bra = pick_source(op.sel_a, op.br_src_a, mem_v, wb_v);
        brb = pick_source(op.sel_b, op.br_src_b, mem_v, wb_v);
        e.name         = name;
        e.op           = op;
        e.mem_res      = mem_v;
        e.wb_res       = wb_v;
        e.rs1          = rs1;
        e.rs2          = rs2;
        e.stall_cycles = cycles;
        e.exp_mem.valid          = op.valid;
        e.exp_mem.alu_res        = ref_result(op.opcode, a, b, bra);
        e.exp_mem.rf_we          = op.rf_we;
        e.exp_mem.rf_waddr       = op.rf_waddr;
        e.exp_mem.st_data        = pick_source(op.sel_st, op.st_data, mem_v, wb_v);
        e.exp_mem.memop_type     = op.memop_type;
        e.exp_mem.memop_rd       = op.memop_rd;
        e.exp_mem.memop_wr       = op.memop_wr;
        e.exp_mem.memop_sign_ext = op.memop_sign_ext;
        e.exp_mem.seq_pc         = op.pc + 32'd4;
        e.exp_mem.is_jal         = op.is_jal;
        e.exp_redirect.taken     = op.valid && ref_taken(op.opcode, bra, brb);
        e.exp_redirect.new_pc    = a + b;
        vectors_q.push_back(e);
    endtask

    task automatic add_branch(input string name, input alu_opcode_e opc,
            input logic [WORD_SIZE-1:0] x, input logic [WORD_SIZE-1:0] y);
        id_ex_t op;
        op = make_op(opc);
        op.rf_we    = 1'b0;
        op.br_src_a = x;
        op.br_src_b = y;
        add_entry(name, op, rand_bits(32), rand_bits(32), '0, '0, 0);
    endtask

    task automatic build_vectors();
        id_ex_t      op;
        logic [31:0] w;
        logic [30:0] m;
        logic [30:0] n;
        for (int i = 0; i < 10; i++) begin
            op = make_op(alu_opcode_e'(i));
            add_entry({"alu_", op.opcode.name()}, op, rand_bits(32), rand_bits(32), '0, '0, 0);
        end
        // Bypass on both operand pairs and on the store data
        op = make_op(ALU_ADD);
        op.sel_a    = MEM_BYPASS;
        op.sel_b    = WB_BYPASS;
        op.sel_st   = MEM_BYPASS;
        op.memop_wr = 1'b1;
        add_entry("fwd_mem_a_wb_b", op, rand_bits(32), rand_bits(32), '0, '0, 0);
        op = make_op(ALU_SUB);
        op.sel_a  = WB_BYPASS;
        op.sel_b  = MEM_BYPASS;
        op.sel_st = WB_BYPASS;
        add_entry("fwd_wb_a_mem_b", op, rand_bits(32), rand_bits(32), '0, '0, 0);
        op = make_op(ALU_BEQ);
        op.sel_a = MEM_BYPASS;
        op.sel_b = MEM_BYPASS;
        add_entry("fwd_beq_mem", op, rand_bits(32), rand_bits(32), '0, '0, 0);
        op = make_op(ALU_BNE);
        op.sel_a = WB_BYPASS;
        op.sel_b = WB_BYPASS;
        add_entry("fwd_bne_wb", op, rand_bits(32), rand_bits(32), '0, '0, 0);
        w = rand_bits(32);
        m = 31'(rand_bits(31));
        n = 31'(rand_bits(31));
        add_branch("beq_taken", ALU_BEQ, w, w);
        add_branch("beq_not_taken", ALU_BEQ, w, w ^ 32'd1);
        add_branch("bne_taken", ALU_BNE, w, w ^ 32'd1);
        add_branch("bne_not_taken", ALU_BNE, w, w);
        add_branch("blt_taken", ALU_BLT, {1'b1, m}, {1'b0, n});
        add_branch("blt_not_taken", ALU_BLT, {1'b0, n}, {1'b1, m});
        add_branch("bge_taken", ALU_BGE, {1'b0, n}, {1'b1, m});
        add_branch("bge_not_taken", ALU_BGE, {1'b1, m}, {1'b0, n});
        op = make_op(ALU_JAL);
        op.br_src_a = op.pc + 32'd4;
        add_entry("jal", op, rand_bits(32), rand_bits(32), '0, '0, 0);
        // Load-use pairs, then a load to x0
        op = make_op(ALU_ADD);
        op.memop_rd = 1'b1;
        op.rf_waddr = 5'd5;
        add_entry("load_x5", op, rand_bits(32), rand_bits(32), '0, '0, 0);
        add_entry("use_x5_rs1", make_op(ALU_OR), rand_bits(32), rand_bits(32), 5'd5, 5'd9, 1);
        op.rf_waddr = 5'd7;
        add_entry("load_x7", op, rand_bits(32), rand_bits(32), '0, '0, 0);
        add_entry("use_x7_rs2", make_op(ALU_AND), rand_bits(32), rand_bits(32), 5'd3, 5'd7, 1);
        op.rf_waddr = 5'd0;
        op.rf_we    = 1'b0;
        add_entry("load_x0", op, rand_bits(32), rand_bits(32), '0, '0, 0);
        add_entry("use_x0", make_op(ALU_SUB), rand_bits(32), rand_bits(32), '0, '0, 0);
        add_entry("mul", make_op(ALU_MUL), rand_bits(32), rand_bits(32), '0, '0, 0);
        add_entry("after_mul", make_op(ALU_XOR), rand_bits(32), rand_bits(32), '0, '0,
                  WORD_SIZE + 1);
        op = make_op(ALU_ADD);
        op.valid = 1'b0;
        add_entry("idle", op, rand_bits(32), rand_bits(32), '0, '0, 0);
    endtask

    task automatic stop_on_error();
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_ex_mem(input string name, input ex_mem_t exp, input ex_mem_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %s ex_mem expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    // new_pc only carries meaning when taken
    task automatic check_redirect(input string name, input redirect_t exp, input redirect_t act);
        if (act.taken !== exp.taken || (exp.taken && act.new_pc !== exp.new_pc)) begin
            $display("CHECK FAILED %s redirect expected %h actual %h", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_stall(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s stall expected %b actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("CHECK FAILED %s stall cycles expected %0d actual %0d", name, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_result(input vector_t e);
        check_ex_mem(e.name, e.exp_mem, ex_mem);
        check_redirect(e.name, e.exp_redirect, redirect);
    endtask

    initial begin
        wait (vectors_ready);
        #((vectors_q.size() * (WORD_SIZE + 4) + 12) * 10);
        $display("Watchdog expired, the DUT stopped making progress");
        stop_on_error();
    end

    initial begin
        int waited;
        rst_n   = 1'b0;
        id_ex   = '0;
        id_rs1  = '0;
        id_rs2  = '0;
        mem_res = '0;
        wb_res  = '0;
        build_vectors();
        vectors_ready = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        check_bit("reset valid", 1'b0, ex_mem.valid);
        check_bit("reset rf_we", 1'b0, ex_mem.rf_we);
        check_bit("reset memop_rd", 1'b0, ex_mem.memop_rd);
        check_bit("reset memop_wr", 1'b0, ex_mem.memop_wr);
        check_bit("reset taken", 1'b0, redirect.taken);
        check_stall("reset", 1'b0, stall);
        rst_n = 1'b1;

        for (int k = 0; k < vectors_q.size(); k++) begin
            @(negedge clk);
            // Sample before the forwarded values change
            if (k > 0 && vectors_q[k-1].op.opcode != ALU_MUL) begin
                check_result(vectors_q[k-1]);
            end
            id_ex   = vectors_q[k].op;
            id_rs1  = vectors_q[k].rs1;
            id_rs2  = vectors_q[k].rs2;
            mem_res = vectors_q[k].mem_res;
            wb_res  = vectors_q[k].wb_res;
            #1;
            check_stall(vectors_q[k].name, vectors_q[k].stall_cycles != 0, stall);
            waited = 0;
            while (stall === 1'b1) begin
                if (vectors_q[k].stall_cycles > 1) begin
                    check_bit({vectors_q[k].name, " valid while stalled"}, 1'b0, ex_mem.valid);
                end
                @(negedge clk);
                #1;
                waited++;
            end
            check_cycles(vectors_q[k].name, vectors_q[k].stall_cycles, waited);
            if (vectors_q[k].stall_cycles == 1) begin
                check_bit({vectors_q[k].name, " bubble valid"}, 1'b0, ex_mem.valid);
                check_bit({vectors_q[k].name, " bubble rf_we"}, 1'b0, ex_mem.rf_we);
            end
            // Product shows once the stall drops
            if (k > 0 && vectors_q[k-1].op.opcode == ALU_MUL) begin
                check_result(vectors_q[k-1]);
            end
            @(posedge clk);
        end
        @(negedge clk);
        check_result(vectors_q[vectors_q.size()-1]);

        $display("test passed");
        $finish;
    end

endmodule : ex_subsys_tb

`default_nettype wire

// ==== ex_subsys.f ====
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_iter_counter.sv
rtl/ex_mul_unit.sv
rtl/ex_hazard_ctrl.sv
rtl/ex_stage.sv
rtl/ex_subsys.sv
bench/ex_subsys_tb.sv

// ==== rtl/ex_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_alu import ex_pkg::*; (
    input  alu_opcode_e          opcode_i,
    input  logic [WORD_SIZE-1:0] src_a_i,
    input  logic [WORD_SIZE-1:0] src_b_i,
    input  logic [WORD_SIZE-1:0] br_a_i,
    input  logic [WORD_SIZE-1:0] br_b_i,
    output logic [WORD_SIZE-1:0] res_o,
    output logic                 taken_o
);

    localparam int SHAMT_W = $clog2(WORD_SIZE);

    logic [SHAMT_W-1:0]   shamt;
    logic [WORD_SIZE-1:0] sum;

    assign shamt = src_b_i[SHAMT_W-1:0];
    assign sum   = src_a_i + src_b_i;

    always_comb begin
        case (opcode_i)
            ALU_SUB:  res_o = src_a_i - src_b_i;
            ALU_AND:  res_o = src_a_i & src_b_i;
            ALU_OR:   res_o = src_a_i | src_b_i;
            ALU_XOR:  res_o = src_a_i ^ src_b_i;
            ALU_SLL:  res_o = src_a_i << shamt;
            ALU_SRL:  res_o = src_a_i >> shamt;
            ALU_SRA:  res_o = WORD_SIZE'($signed(src_a_i) >>> shamt);
            ALU_SLT:  res_o = {{(WORD_SIZE-1){1'b0}}, $signed(src_a_i) < $signed(src_b_i)};
            ALU_SLTU: res_o = {{(WORD_SIZE-1){1'b0}}, src_a_i < src_b_i};
            // Multiply result comes from the iterative unit
            ALU_MUL:  res_o = '0;
            // ADD, branch and jump targets
            default:  res_o = sum;
        endcase
    end

    // Condition on the branch operands
    always_comb begin
        case (opcode_i)
            ALU_BEQ: taken_o = (br_a_i == br_b_i);
            ALU_BNE: taken_o = (br_a_i != br_b_i);
            ALU_BLT: taken_o = ($signed(br_a_i) < $signed(br_b_i));
            ALU_BGE: taken_o = ($signed(br_a_i) >= $signed(br_b_i));
            ALU_JAL: taken_o = 1'b1;
            default: taken_o = 1'b0;
        endcase
    end

endmodule : ex_alu

`default_nettype wire

// ==== rtl/ex_hazard_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_hazard_ctrl import ex_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                id_valid_i,
    input  logic [REG_SIZE-1:0] id_rs1_i,
    input  logic [REG_SIZE-1:0] id_rs2_i,
    input  logic                ex_valid_i,
    input  logic                ex_is_load_i,
    input  logic                ex_is_mul_i,
    input  logic [REG_SIZE-1:0] ex_rf_waddr_i,
    input  logic                mul_done_i,
    output hz_state_e           state_o,
    output logic                hold_o,
    output logic                bubble_o,
    output logic                mul_start_o,
    output logic                stall_o
);

    hz_state_e state_q;
    hz_state_e state_d;
    logic      load_use;

    // x0 is never a real dependency
    assign load_use = id_valid_i && ex_valid_i && ex_is_load_i
                      && (ex_rf_waddr_i != '0)
                      && ((id_rs1_i == ex_rf_waddr_i) || (id_rs2_i == ex_rf_waddr_i));

    assign state_o = state_q;

    always_comb begin
        state_d     = state_q;
        hold_o      = 1'b0;
        bubble_o    = 1'b0;
        mul_start_o = 1'b0;
        stall_o     = 1'b0;
        case (state_q)
            HZ_RUN: begin
                if (ex_valid_i && ex_is_mul_i) begin
                    mul_start_o = 1'b1;
                    hold_o      = 1'b1;
                    stall_o     = 1'b1;
                    state_d     = HZ_MUL;
                end else if (load_use) begin
                    bubble_o = 1'b1;
                    stall_o  = 1'b1;
                    state_d  = HZ_LOADUSE;
                end
            end
            HZ_MUL: begin
                // Release on done so ID hands over its next op
                if (mul_done_i) begin
                    state_d = HZ_RUN;
                end else begin
                    hold_o  = 1'b1;
                    stall_o = 1'b1;
                end
            end
            // Bubble sits in EX, the waiting op enters now
            HZ_LOADUSE: state_d = HZ_RUN;
            default:    state_d = HZ_RUN;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= HZ_RUN;
        end else begin
            state_q <= state_d;
        end
    end

endmodule : ex_hazard_ctrl

`default_nettype wire

// ==== rtl/ex_iter_counter.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_iter_counter #(
    parameter int MUL_STEPS = 32
) (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic start_i,
    output logic step_o,
    output logic done_o
);

    localparam int CNT_W = $clog2(MUL_STEPS + 1);

    logic [CNT_W-1:0] count_q;
    logic             busy_q;

    assign step_o = (count_q != '0);
    // Busy with nothing left to count
    assign done_o = busy_q && (count_q == '0);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            busy_q  <= 1'b0;
        end else if (start_i) begin
            count_q <= CNT_W'(MUL_STEPS);
            busy_q  <= 1'b1;
        end else begin
            if (step_o) begin
                count_q <= count_q - 1'b1;
            end
            if (done_o) begin
                busy_q <= 1'b0;
            end
        end
    end

endmodule : ex_iter_counter

`default_nettype wire

// ==== rtl/ex_mul_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_mul_unit #(
    parameter int WORD_SIZE = 32
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 start_i,
    input  logic                 step_i,
    input  logic [WORD_SIZE-1:0] a_i,
    input  logic [WORD_SIZE-1:0] b_i,
    output logic [WORD_SIZE-1:0] product_o
);

    logic [WORD_SIZE-1:0] mcand_q;
    logic [WORD_SIZE-1:0] mplier_q;
    logic [WORD_SIZE-1:0] acc_q;

    assign product_o = acc_q;

    // Partial products above bit WORD_SIZE-1 are dropped
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mplier_q <= '0;
            acc_q    <= '0;
        end else if (start_i) begin
            mcand_q  <= a_i;
            mplier_q <= b_i;
            acc_q    <= '0;
        end else if (step_i) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;
        end
    end

endmodule : ex_mul_unit

`default_nettype wire

// ==== rtl/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int WORD_SIZE = 32;
    localparam int ADDR_SIZE = 32;
    localparam int REG_SIZE  = 5;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU,
        ALU_BEQ,
        ALU_BNE,
        ALU_BLT,
        ALU_BGE,
        ALU_JAL,
        ALU_MUL
    } alu_opcode_e;

    typedef enum logic [1:0] {
        NO_BYPASS,
        MEM_BYPASS,
        WB_BYPASS
    } bypass_sel_e;

    typedef enum logic [1:0] {
        BYTE,
        HALF,
        WORD
    } memop_type_e;

    typedef enum logic [1:0] {
        HZ_RUN,
        HZ_MUL,
        HZ_LOADUSE
    } hz_state_e;

    // Decoded operation handed over by ID
    typedef struct packed {
        logic                 valid;
        alu_opcode_e          opcode;
        logic [WORD_SIZE-1:0] alu_src_a;
        logic [WORD_SIZE-1:0] alu_src_b;
        logic [WORD_SIZE-1:0] br_src_a;
        logic [WORD_SIZE-1:0] br_src_b;
        logic [ADDR_SIZE-1:0] pc;
        logic                 rf_we;
        logic [REG_SIZE-1:0]  rf_waddr;
        logic [WORD_SIZE-1:0] st_data;
        memop_type_e          memop_type;
        logic                 memop_rd;
        logic                 memop_wr;
        logic                 memop_sign_ext;
        logic                 is_jal;
        bypass_sel_e          sel_a;
        bypass_sel_e          sel_b;
        bypass_sel_e          sel_st;
    } id_ex_t;

    typedef struct packed {
        logic                 valid;
        logic [WORD_SIZE-1:0] alu_res;
        logic                 rf_we;
        logic [REG_SIZE-1:0]  rf_waddr;
        logic [WORD_SIZE-1:0] st_data;
        memop_type_e          memop_type;
        logic                 memop_rd;
        logic                 memop_wr;
        logic                 memop_sign_ext;
        logic [ADDR_SIZE-1:0] seq_pc;
        logic                 is_jal;
    } ex_mem_t;

    typedef struct packed {
        logic                 taken;
        logic [ADDR_SIZE-1:0] new_pc;
    } redirect_t;

endpackage : ex_pkg

`default_nettype wire

// ==== rtl/ex_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_stage import ex_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  id_ex_t               id_ex_i,
    input  logic [WORD_SIZE-1:0] mem_res_i,
    input  logic [WORD_SIZE-1:0] wb_res_i,
    input  logic                 hold_i,
    input  logic                 bubble_i,
    input  logic [WORD_SIZE-1:0] product_i,
    input  logic                 mul_done_i,
    output logic                 ex_is_load_o,
    output logic                 ex_is_mul_o,
    output logic [REG_SIZE-1:0]  ex_rf_waddr_o,
    output logic                 ex_valid_o,
    output logic [WORD_SIZE-1:0] mul_a_o,
    output logic [WORD_SIZE-1:0] mul_b_o,
    output ex_mem_t              ex_mem_o,
    output redirect_t            redirect_o
);

    id_ex_t               ex_q;
    logic [ADDR_SIZE-1:0] seq_pc_q;

    logic [WORD_SIZE-1:0] src_a;
    logic [WORD_SIZE-1:0] src_b;
    logic [WORD_SIZE-1:0] br_a;
    logic [WORD_SIZE-1:0] br_b;
    logic [WORD_SIZE-1:0] st_data;
    logic [WORD_SIZE-1:0] alu_res;
    logic                 alu_taken;
    logic                 is_mul;
    logic                 mul_pending;

    function automatic logic [WORD_SIZE-1:0] fwd(
        input bypass_sel_e          sel,
        input logic [WORD_SIZE-1:0] rf_val,
        input logic [WORD_SIZE-1:0] mem_val,
        input logic [WORD_SIZE-1:0] wb_val
    );
        case (sel)
            MEM_BYPASS: return mem_val;
            WB_BYPASS:  return wb_val;
            default:    return rf_val;
        endcase
    endfunction

    // ID/EX decoupling register
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_q.valid    <= 1'b0;
            ex_q.rf_we    <= 1'b0;
            ex_q.memop_rd <= 1'b0;
            ex_q.memop_wr <= 1'b0;
            ex_q.sel_a    <= NO_BYPASS;
            ex_q.sel_b    <= NO_BYPASS;
            ex_q.sel_st   <= NO_BYPASS;
        end else if (!hold_i) begin
            ex_q     <= id_ex_i;
            seq_pc_q <= id_ex_i.pc + ADDR_SIZE'(4);
            // NOP injection, later assignments win
            if (bubble_i) begin
                ex_q.valid    <= 1'b0;
                ex_q.rf_we    <= 1'b0;
                ex_q.memop_rd <= 1'b0;
                ex_q.memop_wr <= 1'b0;
            end
        end
    end

    assign src_a   = fwd(ex_q.sel_a, ex_q.alu_src_a, mem_res_i, wb_res_i);
    assign br_a    = fwd(ex_q.sel_a, ex_q.br_src_a, mem_res_i, wb_res_i);
    assign src_b   = fwd(ex_q.sel_b, ex_q.alu_src_b, mem_res_i, wb_res_i);
    assign br_b    = fwd(ex_q.sel_b, ex_q.br_src_b, mem_res_i, wb_res_i);
    assign st_data = fwd(ex_q.sel_st, ex_q.st_data, mem_res_i, wb_res_i);

    ex_alu u_alu (
        .opcode_i (ex_q.opcode),
        .src_a_i  (src_a),
        .src_b_i  (src_b),
        .br_a_i   (br_a),
        .br_b_i   (br_b),
        .res_o    (alu_res),
        .taken_o  (alu_taken)
    );

    assign is_mul      = (ex_q.opcode == ALU_MUL);
    assign mul_pending = is_mul && !mul_done_i;

    // Controller view of the op sitting in EX
    assign ex_is_load_o  = ex_q.memop_rd;
    assign ex_is_mul_o   = is_mul;
    assign ex_rf_waddr_o = ex_q.rf_waddr;
    assign ex_valid_o    = ex_q.valid;

    assign mul_a_o = src_a;
    assign mul_b_o = src_b;

    always_comb begin
        ex_mem_o.valid = ex_q.valid && !mul_pending;
        if (is_mul && mul_done_i) begin
            ex_mem_o.alu_res = product_i;
        end else if (ex_q.opcode == ALU_JAL) begin
            // Return address arrives on the branch A operand
            ex_mem_o.alu_res = br_a;
        end else begin
            ex_mem_o.alu_res = alu_res;
        end
        ex_mem_o.rf_we          = ex_q.rf_we;
        ex_mem_o.rf_waddr       = ex_q.rf_waddr;
        ex_mem_o.st_data        = st_data;
        ex_mem_o.memop_type     = ex_q.memop_type;
        ex_mem_o.memop_rd       = ex_q.memop_rd;
        ex_mem_o.memop_wr       = ex_q.memop_wr;
        ex_mem_o.memop_sign_ext = ex_q.memop_sign_ext;
        ex_mem_o.seq_pc         = seq_pc_q;
        ex_mem_o.is_jal         = ex_q.is_jal;
    end

    assign redirect_o.taken  = ex_q.valid && alu_taken;
    assign redirect_o.new_pc = alu_res[ADDR_SIZE-1:0];

endmodule : ex_stage

`default_nettype wire

// ==== rtl/ex_subsys.sv ====
`timescale 1ns/10ps
`default_nettype none

module ex_subsys import ex_pkg::*; #(
    parameter int WORD_SIZE = ex_pkg::WORD_SIZE,
    parameter int MUL_STEPS = WORD_SIZE
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  id_ex_t               id_ex_i,
    input  logic [REG_SIZE-1:0]  id_rs1_i,
    input  logic [REG_SIZE-1:0]  id_rs2_i,
    input  logic [WORD_SIZE-1:0] mem_res_i,
    input  logic [WORD_SIZE-1:0] wb_res_i,
    output ex_mem_t              ex_mem_o,
    output redirect_t            redirect_o,
    output logic                 stall_o
);

    logic                 hold;
    logic                 bubble;
    logic                 mul_start;
    logic                 step;
    logic                 cnt_done;
    logic                 mul_done;
    logic [WORD_SIZE-1:0] product;
    logic                 ex_is_load;
    logic                 ex_is_mul;
    logic [REG_SIZE-1:0]  ex_rf_waddr;
    logic                 ex_valid;
    logic [WORD_SIZE-1:0] mul_a;
    logic [WORD_SIZE-1:0] mul_b;
    hz_state_e            hz_state;

    // Completion only counts while the controller waits on the multiplier
    assign mul_done = cnt_done && (hz_state == HZ_MUL);

    ex_stage u_stage (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .id_ex_i       (id_ex_i),
        .mem_res_i     (mem_res_i),
        .wb_res_i      (wb_res_i),
        .hold_i        (hold),
        .bubble_i      (bubble),
        .product_i     (product),
        .mul_done_i    (mul_done),
        .ex_is_load_o  (ex_is_load),
        .ex_is_mul_o   (ex_is_mul),
        .ex_rf_waddr_o (ex_rf_waddr),
        .ex_valid_o    (ex_valid),
        .mul_a_o       (mul_a),
        .mul_b_o       (mul_b),
        .ex_mem_o      (ex_mem_o),
        .redirect_o    (redirect_o)
    );

    ex_hazard_ctrl u_hazard (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .id_valid_i    (id_ex_i.valid),
        .id_rs1_i      (id_rs1_i),
        .id_rs2_i      (id_rs2_i),
        .ex_valid_i    (ex_valid),
        .ex_is_load_i  (ex_is_load),
        .ex_is_mul_i   (ex_is_mul),
        .ex_rf_waddr_i (ex_rf_waddr),
        .mul_done_i    (mul_done),
        .state_o       (hz_state),
        .hold_o        (hold),
        .bubble_o      (bubble),
        .mul_start_o   (mul_start),
        .stall_o       (stall_o)
    );

    ex_iter_counter #(
        .MUL_STEPS (MUL_STEPS)
    ) u_counter (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .start_i (mul_start),
        .step_o  (step),
        .done_o  (cnt_done)
    );

    ex_mul_unit #(
        .WORD_SIZE (WORD_SIZE)
    ) u_mul (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .start_i   (mul_start),
        .step_i    (step),
        .a_i       (mul_a),
        .b_i       (mul_b),
        .product_o (product)
    );

endmodule : ex_subsys

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the execute-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module ex_subsys_tb \
    -f ex_subsys.f -o ex_subsys_sim > build.log 2>&1 \
    || { cat build.log; echo "Verilator build error"; exit 1; }

./obj_dir/ex_subsys_sim > sim.log 2>&1
cat sim.log

grep -q "test failed" sim.log && exit 1 || grep -q "test passed" sim.log || exit 1
exit 0
